// File: list.f
+incdir+.
addr_map_pkg.sv
addr_map_regs.sv
addr_decode_dync.sv
req_steer.sv
addr_router_top.sv
addr_router_checker.sv
addr_router_tb.sv

// File: run.sh
#!/bin/sh
# Build the simulator from list.f, run it and look for the pass line in its output

verilator --binary --timing --assert -f list.f --top-module addr_router_tb -o sim_router \
  && sim_out="$(./obj_dir/sim_router)" \
  ; echo "$sim_out" \
  ; echo "$sim_out" | grep -qx "Done: no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: addr_router_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module addr_router_tb;
  import addr_map_pkg::*;

  // Result codes of the reference model; ports take the codes below NO_PORTS
  localparam int KIND_ERR   = `NO_PORTS;
  localparam int KIND_RETRY = `NO_PORTS + 1;
  localparam int KIND_NONE  = `NO_PORTS + 2;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 cfg_we;
  logic                 cfg_commit;
  rule_sel_t            cfg_rule;
  cfg_field_t           cfg_field;
  addr_t                cfg_wdata;
  logic                 req_valid;
  addr_t                req_addr;
  data_t                req_data;
  logic [`NO_PORTS-1:0] port_valid;
  addr_t                port_addr;
  data_t                port_data;
  logic                 dec_err;
  logic                 retry;

  // Shadow of the map as the register bank holds it
  addr_t sh_start [`NO_RULES];
  addr_t sh_end   [`NO_RULES];
  idx_t  sh_idx   [`NO_RULES];
  logic  sh_en_default;
  idx_t  sh_default_idx;
  logic  sh_ongoing;

  // Prediction for the result due on the next falling edge
  int                   exp_kind = KIND_NONE;
  addr_t                exp_addr;
  data_t                exp_data;
  logic [`NO_PORTS-1:0] exp_port_vec = '0;
  logic                 got_any;

  int predicted_count = 0;
  int checked_count   = 0;
  int port_seen       = 0;
  int err_seen        = 0;
  int retry_seen      = 0;
  int value_errors    = 0;
  int order_errors    = 0;
  int timeouts        = 0;

  logic [31:0] lfsr_state = 32'h0000_7b7e;

  addr_router_top uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .cfg_we_i     (cfg_we),
    .cfg_commit_i (cfg_commit),
    .cfg_rule_i   (cfg_rule),
    .cfg_field_i  (cfg_field),
    .cfg_wdata_i  (cfg_wdata),
    .req_valid_i  (req_valid),
    .req_addr_i   (req_addr),
    .req_data_i   (req_data),
    .port_valid_o (port_valid),
    .port_addr_o  (port_addr),
    .port_data_o  (port_data),
    .dec_err_o    (dec_err),
    .retry_o      (retry)
  );

  always #50 clk = ~clk;

  // Galois form, shifting right with the feedback taps 32, 30, 26 and 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Routing rule worked out from the shadow map
  // Highest matching rule wins, an end of zero is open towards the top
  function automatic int expect_route(input addr_t addr);
    int hit;
    hit = -1;
    if (sh_ongoing) begin
      return KIND_RETRY;
    end
    for (int r = 0; r < `NO_RULES; r++) begin
      if ((addr >= sh_start[r]) && ((addr < sh_end[r]) || (sh_end[r] == '0))) begin
        hit = r;
      end
    end
    if (hit >= 0) begin
      return int'(sh_idx[hit]);
    end
    if (sh_en_default) begin
      return int'(sh_default_idx);
    end
    return KIND_ERR;
  endfunction

  // Mirror the write and commit that the bank takes on the coming edge
  task automatic record_config();
    if (cfg_we) begin
      case (cfg_field)
        CFG_START: sh_start[cfg_rule] = cfg_wdata;
        CFG_END:   sh_end[cfg_rule] = cfg_wdata;
        CFG_IDX:   sh_idx[cfg_rule] = cfg_wdata[`IDX_WIDTH-1:0];
        default: begin
          sh_en_default  = cfg_wdata[`IDX_WIDTH];
          sh_default_idx = cfg_wdata[`IDX_WIDTH-1:0];
        end
      endcase
    end
    if (cfg_commit) begin
      sh_ongoing = 1'b0;
    end else if (cfg_we) begin
      sh_ongoing = 1'b1;
    end
  endtask

  // Falling edge, halfway between the edges where inputs and outputs move
  always @(negedge clk) begin
    got_any = (port_valid != '0) || dec_err || retry;
    if (exp_kind == KIND_NONE) begin
      assert (!got_any) else begin
        order_errors++;
        $display("Unexpected result at %0t with no request one cycle earlier", $time);
      end
    end else begin
      checked_count++;
      assert (got_any) else begin
        order_errors++;
        $display("Missing result at %0t: no port strobe, decode error or retry", $time);
      end
      if (got_any) begin
        assert (port_valid == exp_port_vec) else begin
          value_errors++;
          $display("CHECK FAILED at %0t: port_valid_o is %b, expected %b",
                   $time, port_valid, exp_port_vec);
        end
        assert (dec_err == (exp_kind == KIND_ERR)) else begin
          value_errors++;
          $display("CHECK FAILED at %0t: dec_err_o is %b", $time, dec_err);
        end
        assert (retry == (exp_kind == KIND_RETRY)) else begin
          value_errors++;
          $display("CHECK FAILED at %0t: retry_o is %b", $time, retry);
        end
        // Address and data only mean something next to a port strobe
        if (exp_kind < `NO_PORTS) begin
          assert (port_addr == exp_addr) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: port_addr_o is %h, expected %h",
                     $time, port_addr, exp_addr);
          end
          assert (port_data == exp_data) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: port_data_o is %h, expected %h",
                     $time, port_data, exp_data);
          end
        end
      end
    end
    if (port_valid != '0) port_seen++;
    if (dec_err) err_seen++;
    if (retry) retry_seen++;

    // Predict from the inputs the DUT samples on the next rising edge
    exp_kind     = KIND_NONE;
    exp_port_vec = '0;
    if (!rst_n) begin
      for (int r = 0; r < `NO_RULES; r++) begin
        sh_start[r] = '0;
        sh_end[r]   = '0;
        sh_idx[r]   = '0;
      end
      sh_en_default  = 1'b0;
      sh_default_idx = '0;
      sh_ongoing     = 1'b1;
    end else begin
      if (req_valid) begin
        exp_kind = expect_route(req_addr);
        exp_addr = req_addr;
        exp_data = req_data;
        predicted_count++;
        if (exp_kind < `NO_PORTS) begin
          exp_port_vec = {{(`NO_PORTS-1){1'b0}}, 1'b1} << exp_kind;
        end
      end
      // The request above still sees the map from before this write
      record_config();
    end
  end

  // One clock of stimulus, every input set on the rising edge
  task automatic drive_cycle(input logic we, input logic commit, input rule_sel_t rule,
                             input cfg_field_t field, input addr_t wdata,
                             input logic rv, input addr_t addr, input data_t data);
    @(posedge clk);
    cfg_we     <= we;
    cfg_commit <= commit;
    cfg_rule   <= rule;
    cfg_field  <= field;
    cfg_wdata  <= wdata;
    req_valid  <= rv;
    req_addr   <= addr;
    req_data   <= data;
  endtask

  task automatic cfg_write(input rule_sel_t rule, input cfg_field_t field, input addr_t wdata);
    drive_cycle(1'b1, 1'b0, rule, field, wdata, 1'b0, '0, '0);
  endtask

  task automatic set_rule(input rule_sel_t rule, input addr_t start, input addr_t stop,
                          input idx_t idx);
    cfg_write(rule, CFG_START, start);
    cfg_write(rule, CFG_END, stop);
    cfg_write(rule, CFG_IDX, {{(`ADDR_WIDTH-`IDX_WIDTH){1'b0}}, idx});
  endtask

  task automatic set_default(input logic en, input idx_t idx);
    addr_t wdata;
    wdata = '0;
    wdata[`IDX_WIDTH] = en;
    wdata[`IDX_WIDTH-1:0] = idx;
    cfg_write('0, CFG_DEFAULT, wdata);
  endtask

  task automatic commit_map();
    drive_cycle(1'b0, 1'b1, '0, '0, '0, 1'b0, '0, '0);
  endtask

  task automatic send_req(input addr_t addr);
    data_t data;
    data = take_bits(`DATA_WIDTH);
    drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b1, addr, data);
  endtask

  // Random offset of nbits above the base
  task automatic send_in_range(input addr_t base, input int nbits);
    send_req(base + take_bits(nbits));
  endtask

  // Idle cycle, then wait until every request has been checked
  task automatic drain_results(input int limit);
    int waited;
    waited = 0;
    drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0);
    while ((checked_count != predicted_count) && (waited < limit)) begin
      @(posedge clk);
      waited++;
    end
    if (checked_count != predicted_count) begin
      timeouts++;
      $display("Timeout after %0d cycles: %0d requests still have no result",
               limit, predicted_count - checked_count);
    end
  endtask

  initial begin
    int retry_mark;
    int err_mark;
    int total;
    rst_n      = 1'b0;
    cfg_we     = 1'b0;
    cfg_commit = 1'b0;
    cfg_rule   = '0;
    cfg_field  = '0;
    cfg_wdata  = '0;
    req_valid  = 1'b0;
    req_addr   = '0;
    req_data   = '0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
    end
    rst_n <= 1'b1;

    // Nothing has been committed yet, so every request bounces
    retry_mark = retry_seen;
    for (int i = 0; i < 6; i++) begin
      send_req(take_bits(`ADDR_WIDTH));
    end
    drain_results(10);
    assert (retry_seen - retry_mark == 6) else begin
      value_errors++;
      $display("CHECK FAILED at %0t: %0d retries before the first commit, expected 6",
               $time, retry_seen - retry_mark);
    end

    // Four disjoint windows, the default port stays off
    set_rule(2'd0, 32'h0000_1000, 32'h0000_2000, 2'd2);
    set_rule(2'd1, 32'h1000_0000, 32'h2000_0000, 2'd0);
    set_rule(2'd2, 32'h4000_0000, 32'h4001_0000, 2'd3);
    set_rule(2'd3, 32'h8000_0000, 32'h9000_0000, 2'd1);
    set_default(1'b0, 2'd0);
    commit_map();
    for (int i = 0; i < 4; i++) begin
      send_in_range(32'h0000_1000, 12);
      send_in_range(32'h1000_0000, 28);
      send_in_range(32'h4000_0000, 16);
      send_in_range(32'h8000_0000, 28);
    end
    // Start is inside the window, end is already outside
    send_req(32'h4000_0000);
    send_req(32'h4001_0000);
    send_in_range(32'h3000_0000, 28);
    send_in_range(32'hA000_0000, 28);
    send_in_range(32'h0000_0000, 12);
    drain_results(10);

    // Rule 3 now covers the upper half of rule 1 and beyond
    set_rule(2'd3, 32'h1800_0000, 32'h2800_0000, 2'd1);
    commit_map();
    for (int i = 0; i < 6; i++) begin
      send_in_range(32'h1800_0000, 27);
      send_in_range(32'h1000_0000, 27);
      send_in_range(32'h2000_0000, 27);
    end
    drain_results(10);

    // Open-ended rule 2 and default port 2 leave no way to a decode error
    set_rule(2'd2, 32'hC000_0000, 32'h0000_0000, 2'd3);
    set_default(1'b1, 2'd2);
    commit_map();
    err_mark = err_seen;
    for (int i = 0; i < 6; i++) begin
      send_in_range(32'hC000_0000, 30);
      send_in_range(32'h5000_0000, 28);
      send_req(take_bits(`ADDR_WIDTH));
    end
    send_req(32'hFFFF_FFFF);
    drain_results(10);
    assert (err_seen == err_mark) else begin
      value_errors++;
      $display("CHECK FAILED at %0t: %0d decode errors with the default enabled",
               $time, err_seen - err_mark);
    end

    // Write in cycle 3 and commit in cycle 7, so requests 4 to 7 retry
    retry_mark = retry_seen;
    for (int c = 0; c < 12; c++) begin
      drive_cycle(c == 3, c == 7, 2'd0, CFG_IDX, 32'h0000_0001, 1'b1,
                  32'h0000_1000 + take_bits(12), take_bits(`DATA_WIDTH));
    end
    drain_results(10);
    assert (retry_seen - retry_mark == 4) else begin
      value_errors++;
      $display("CHECK FAILED at %0t: %0d retries around the rewrite, expected 4",
               $time, retry_seen - retry_mark);
    end

    $display("Results: %0d port strobes, %0d decode errors, %0d retries",
             port_seen, err_seen, retry_seen);
    total = value_errors + order_errors + timeouts;
    $display("Error counts: %0d wrong values, %0d missing or extra results, %0d timeouts",
             value_errors, order_errors, timeouts);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: addr_router_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module addr_router_checker (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  logic [`NO_PORTS-1:0] port_valid_i,
  input  logic                 dec_err_i,
  input  logic                 retry_i
);

  // Set when any kind of result leaves the router in this cycle
  logic any_result;

  assign any_result = (|port_valid_i) || dec_err_i || retry_i;

  // A request goes to one port at most
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(port_valid_i))
    else $error("port_valid_o has more than one bit set");

  // Port strobe, decode error and retry exclude each other
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({|port_valid_i, dec_err_i, retry_i}))
    else $error("more than one kind of result in the same cycle");

  // Nothing comes out without a request one cycle earlier
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    any_result |-> $past(req_valid_i))
    else $error("result without a request in the previous cycle");

  // Every request accepted out of reset gives a result in the next cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(req_valid_i) && $past(rst_n_i)) |-> any_result)
    else $error("request was not followed by a result");

  // Sync reset clears every result strobe on the following edge
  assert property (@(posedge clk_i)
    !rst_n_i |=> ((port_valid_i == '0) && !dec_err_i && !retry_i))
    else $error("result strobes not low during reset");

endmodule

// Attach the checker to every instance of the router top level
bind addr_router_top addr_router_checker u_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_valid_i  (req_valid_i),
  .port_valid_i (port_valid_o),
  .dec_err_i    (dec_err_o),
  .retry_i      (retry_o)
);

`default_nettype wire

// File: addr_router_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module addr_router_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cfg_we_i,
  input  logic                        cfg_commit_i,
  input  addr_map_pkg::rule_sel_t     cfg_rule_i,
  input  addr_map_pkg::cfg_field_t    cfg_field_i,
  input  addr_map_pkg::addr_t         cfg_wdata_i,
  input  logic                        req_valid_i,
  input  addr_map_pkg::addr_t         req_addr_i,
  input  addr_map_pkg::data_t         req_data_i,
  output logic [`NO_PORTS-1:0]        port_valid_o,
  output addr_map_pkg::addr_t         port_addr_o,
  output addr_map_pkg::data_t         port_data_o,
  output logic                        dec_err_o,
  output logic                        retry_o
);
  import addr_map_pkg::*;

  // Address map as held by the register bank
  addr_t [`NO_RULES-1:0] map_start;
  addr_t [`NO_RULES-1:0] map_end;
  idx_t  [`NO_RULES-1:0] map_idx;
  logic                  en_default;
  idx_t                  default_idx;
  logic                  config_ongoing;

  // Decoder verdict for the request in the current cycle
  idx_t dec_idx;
  logic dec_valid;
  logic dec_error;

  addr_map_regs u_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_commit_i     (cfg_commit_i),
    .cfg_rule_i       (cfg_rule_i),
    .cfg_field_i      (cfg_field_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .map_start_o      (map_start),
    .map_end_o        (map_end),
    .map_idx_o        (map_idx),
    .en_default_o     (en_default),
    .default_idx_o    (default_idx),
    .config_ongoing_o (config_ongoing)
  );

  // The decoder sees the raw request address, so the verdict is ready in the request cycle
  addr_decode_dync #(
    .NoRules (`NO_RULES)
  ) u_decode (
    .addr_i           (req_addr_i),
    .map_start_i      (map_start),
    .map_end_i        (map_end),
    .map_idx_i        (map_idx),
    .en_default_i     (en_default),
    .default_idx_i    (default_idx),
    .config_ongoing_i (config_ongoing),
    .idx_o            (dec_idx),
    .dec_valid_o      (dec_valid),
    .dec_error_o      (dec_error)
  );

  req_steer u_steer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .dec_idx_i    (dec_idx),
    .dec_valid_i  (dec_valid),
    .dec_error_i  (dec_error),
    .port_valid_o (port_valid_o),
    .port_addr_o  (port_addr_o),
    .port_data_o  (port_data_o),
    .dec_err_o    (dec_err_o),
    .retry_o      (retry_o)
  );

endmodule

`default_nettype wire

// File: req_steer.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module req_steer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_valid_i,
  input  addr_map_pkg::addr_t         req_addr_i,
  input  addr_map_pkg::data_t         req_data_i,
  input  addr_map_pkg::idx_t          dec_idx_i,
  input  logic                        dec_valid_i,
  input  logic                        dec_error_i,
  output logic [`NO_PORTS-1:0]        port_valid_o,
  output addr_map_pkg::addr_t         port_addr_o,
  output addr_map_pkg::data_t         port_data_o,
  output logic                        dec_err_o,
  output logic                        retry_o
);
  import addr_map_pkg::*;

  // Single register stage between request and result
  // Each request strobe gives exactly one result in the next cycle
  // The result is a port strobe, a decode error or a retry
  // A new request may arrive every cycle since nothing pushes back

  // One-hot form of the decoded index, worked out in the request cycle
  logic [`NO_PORTS-1:0] port_sel;

  // Result strobes, one cycle behind the request
  logic [`NO_PORTS-1:0] port_valid_q;
  logic                 dec_err_q;
  logic                 retry_q;

  // Address and data of the latest request
  addr_t addr_q;
  data_t data_q;

  // Turn the index into a single set bit
  always_comb begin
    port_sel = '0;
    port_sel[dec_idx_i] = 1'b1;
  end

  // Every strobe is cleared each cycle so a result lasts exactly one cycle
  // Valid goes first, then error, and anything else is a retry
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      port_valid_q <= '0;
      dec_err_q    <= 1'b0;
      retry_q      <= 1'b0;
    end else begin
      port_valid_q <= '0;
      dec_err_q    <= 1'b0;
      retry_q      <= 1'b0;
      if (req_valid_i) begin
        if (dec_valid_i) begin
          port_valid_q <= port_sel;
        end else if (dec_error_i) begin
          dec_err_q <= 1'b1;
        end else begin
          retry_q <= 1'b1;
        end
      end
    end
  end

  // Payload follows the request strobe and is only meaningful with a port strobe
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      addr_q <= req_addr_i;
      data_q <= req_data_i;
    end
  end

  assign port_valid_o = port_valid_q;
  assign port_addr_o  = addr_q;
  assign port_data_o  = data_q;
  assign dec_err_o    = dec_err_q;
  assign retry_o      = retry_q;

endmodule

`default_nettype wire

// File: addr_decode_dync.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module addr_decode_dync #(
  parameter int unsigned NoRules = `NO_RULES
) (
  input  addr_map_pkg::addr_t                 addr_i,
  input  addr_map_pkg::addr_t [NoRules-1:0]   map_start_i,
  input  addr_map_pkg::addr_t [NoRules-1:0]   map_end_i,
  input  addr_map_pkg::idx_t  [NoRules-1:0]   map_idx_i,
  input  logic                                en_default_i,
  input  addr_map_pkg::idx_t                  default_idx_i,
  input  logic                                config_ongoing_i,
  output addr_map_pkg::idx_t                  idx_o,
  output logic                                dec_valid_o,
  output logic                                dec_error_o
);
  import addr_map_pkg::*;

  // Purely combinational range decoder
  // A rule covers start up to but excluding end
  // An end of zero stretches the rule to the top of the address space
  // Rules may overlap and the highest numbered match wins

  // One bit per rule that covers the address
  logic [NoRules-1:0] rule_hit;
  // Set when at least one rule covers the address
  logic               any_hit;
  // Port index of the winning rule
  idx_t               hit_idx;

  // Compare against every rule in parallel
  always_comb begin
    rule_hit = '0;
    for (int unsigned i = 0; i < NoRules; i++) begin
      if ((addr_i >= map_start_i[i]) &&
          ((addr_i < map_end_i[i]) || (map_end_i[i] == '0))) begin
        rule_hit[i] = 1'b1;
      end
    end
  end

  // Scan from the lowest rule up, so a later hit overwrites an earlier one
  always_comb begin
    hit_idx = '0;
    for (int unsigned i = 0; i < NoRules; i++) begin
      if (rule_hit[i]) begin
        hit_idx = map_idx_i[i];
      end
    end
  end

  assign any_hit = |rule_hit;

  // Without a hit the default index is offered, which only matters when enabled
  assign idx_o = any_hit ? hit_idx : default_idx_i;

  // A hit or an enabled default gives a usable target
  // During configuration nothing is valid, so the request gets retried
  assign dec_valid_o = (any_hit || en_default_i) && !config_ongoing_i;

  // A real decode error needs a settled map, no hit and no default port
  // Keeping it low during configuration lets the request stage pick retry
  assign dec_error_o = !any_hit && !en_default_i && !config_ongoing_i;

endmodule

`default_nettype wire

// File: addr_map_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defs.svh"

module addr_map_regs (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    cfg_we_i,
  input  logic                                    cfg_commit_i,
  input  addr_map_pkg::rule_sel_t                 cfg_rule_i,
  input  addr_map_pkg::cfg_field_t                cfg_field_i,
  input  addr_map_pkg::addr_t                     cfg_wdata_i,
  output addr_map_pkg::addr_t [`NO_RULES-1:0]     map_start_o,
  output addr_map_pkg::addr_t [`NO_RULES-1:0]     map_end_o,
  output addr_map_pkg::idx_t  [`NO_RULES-1:0]     map_idx_o,
  output logic                                    en_default_o,
  output addr_map_pkg::idx_t                      default_idx_o,
  output logic                                    config_ongoing_o
);
  import addr_map_pkg::*;

  // The bank holds four rules plus one default setting
  // Every write lands one cycle after its strobe
  // The ongoing flag marks the map as possibly inconsistent until a commit

  // One enable per field, decoded from the write strobe
  logic wr_start;
  logic wr_end;
  logic wr_idx;
  logic wr_default;

  // Pieces of the write data used by the index and default fields
  idx_t wdata_idx;
  logic wdata_en;

  // Stored address map
  addr_t [`NO_RULES-1:0] start_q;
  addr_t [`NO_RULES-1:0] end_q;
  idx_t  [`NO_RULES-1:0] idx_q;
  logic                  en_default_q;
  idx_t                  default_idx_q;

  // High while the map is being rewritten
  logic ongoing_q;

  // Only one field is selected per write, so at most one enable is set
  assign wr_start   = cfg_we_i && (cfg_field_i == CFG_START);
  assign wr_end     = cfg_we_i && (cfg_field_i == CFG_END);
  assign wr_idx     = cfg_we_i && (cfg_field_i == CFG_IDX);
  assign wr_default = cfg_we_i && (cfg_field_i == CFG_DEFAULT);

  // The low bits give the port index for both the rule and the default
  assign wdata_idx = cfg_wdata_i[`IDX_WIDTH-1:0];
  // The bit just above the index enables the default port
  assign wdata_en  = cfg_wdata_i[`IDX_WIDTH];

  // Map registers start out empty with the default port disabled
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_q       <= '0;
      end_q         <= '0;
      idx_q         <= '0;
      en_default_q  <= 1'b0;
      default_idx_q <= '0;
    end else begin
      // The rule number picks which entry of the arrays is updated
      if (wr_start) begin
        start_q[cfg_rule_i] <= cfg_wdata_i;
      end
      if (wr_end) begin
        end_q[cfg_rule_i] <= cfg_wdata_i;
      end
      if (wr_idx) begin
        idx_q[cfg_rule_i] <= wdata_idx;
      end
      // The default setting is global and ignores the rule number
      if (wr_default) begin
        en_default_q  <= wdata_en;
        default_idx_q <= wdata_idx;
      end
    end
  end

  // Out of reset the map counts as unconfigured, so nothing routes
  // A commit wins over a write in the same cycle and ends the configuration
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ongoing_q <= 1'b1;
    end else if (cfg_commit_i) begin
      ongoing_q <= 1'b0;
    end else if (cfg_we_i) begin
      ongoing_q <= 1'b1;
    end
  end

  assign map_start_o      = start_q;
  assign map_end_o        = end_q;
  assign map_idx_o        = idx_q;
  assign en_default_o     = en_default_q;
  assign default_idx_o    = default_idx_q;
  assign config_ongoing_o = ongoing_q;

endmodule

`default_nettype wire

// File: addr_map_pkg.sv
`default_nettype none
`include "router_defs.svh"

package addr_map_pkg;

  // One address, also used for the start and end bound of a rule
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  // Payload carried along with a request
  typedef logic [`DATA_WIDTH-1:0] data_t;
  // Index of an output port
  typedef logic [`IDX_WIDTH-1:0]  idx_t;
  // Rule number addressed by a configuration write
  typedef logic [`RULE_WIDTH-1:0] rule_sel_t;
  // Selects which field a configuration write updates
  typedef logic [1:0]             cfg_field_t;

  // Field 0 writes the inclusive start address of the rule
  localparam cfg_field_t CFG_START   = 2'd0;
  // Field 1 writes the exclusive end address, zero meaning the top of memory
  localparam cfg_field_t CFG_END     = 2'd1;
  // Field 2 writes the target port index of the rule
  localparam cfg_field_t CFG_IDX     = 2'd2;
  // Field 3 writes the default setting and ignores the rule number
  // Data bit IDX_WIDTH is the enable and the bits below it are the index
  localparam cfg_field_t CFG_DEFAULT = 2'd3;

endpackage

`default_nettype wire

// File: router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Width of every address and of every rule bound
`define ADDR_WIDTH 32

// Width of the request payload
`define DATA_WIDTH 32

// Number of rules held in the address map
`define NO_RULES 4

// Number of output ports the router steers to
`define NO_PORTS 4

// Width of a port index, enough to name every port
`define IDX_WIDTH 2

// Width of a rule number, enough to name every rule
`define RULE_WIDTH 2

`endif
